//--- Makefile
TOP := tb_apu_pulse
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f tb.f

obj_dir/V$(TOP): tb.f *.sv
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "All tests passed" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

//--- apu_chan_pkg.sv
package apu_chan_pkg;

  localparam int TIMER_W = 11;
  localparam int VOL_W   = 4;
  localparam int AUDIO_W = 5;

  // Same bit layout as the sweep register byte
  typedef struct packed {
    logic       enable;
    logic [2:0] period;
    logic       negate;
    logic [2:0] shift_count;
  } sweep_t;

  // Index 0 is 12.5%, index 3 is 75% (inverted 25%)
  localparam logic [3:0][7:0] DUTY_SEQ = {
    8'b1111_1001,
    8'b0001_1110,
    8'b0000_0110,
    8'b0000_0010
  };

  localparam logic [0:31][7:0] LENGTH_TABLE = {
    8'd10,  8'd254, 8'd20,  8'd2,
    8'd40,  8'd4,   8'd80,  8'd6,
    8'd160, 8'd8,   8'd60,  8'd10,
    8'd14,  8'd12,  8'd26,  8'd14,
    8'd12,  8'd16,  8'd24,  8'd18,
    8'd48,  8'd20,  8'd96,  8'd22,
    8'd192, 8'd24,  8'd72,  8'd26,
    8'd16,  8'd28,  8'd32,  8'd30
  };

endpackage : apu_chan_pkg

//--- apu_ctrl_frontend.sv
`timescale 1ns/1ps

module apu_ctrl_frontend #(parameter int QUARTER_STEP = 3728) (
  input  logic clk, rst_n, cpu_clk_en,
  input  logic wr_en,
  input  logic [apu_reg_pkg::ADDR_W-1:0] addr,
  input  logic [apu_reg_pkg::DATA_W-1:0] wdata,
  output logic apu_clk_en, quarter_clk_en, half_clk_en,
  output logic [1:0] enable,
  pulse_ctrl_if.frontend ch1,
  pulse_ctrl_if.frontend ch2
);

  localparam int CNT_W = $clog2(QUARTER_STEP + 1);

  apu_reg_pkg::apu_reg_e reg_sel;
  logic ch_sel;

  logic [1:0][apu_reg_pkg::DUTY_W-1:0]    duty_q;
  logic [1:0]                             halt_q, const_q;
  logic [1:0][apu_chan_pkg::VOL_W-1:0]    vol_q;
  apu_chan_pkg::sweep_t [1:0]             sweep_q;
  logic [1:0][apu_chan_pkg::TIMER_W-1:0]  period_q;
  logic [1:0][apu_reg_pkg::LEN_IDX_W-1:0] len_idx_q;
  logic [1:0]                             env_load_q, sweep_load_q, length_load_q;

  apu_reg_pkg::frame_mode_e frame_mode;
  logic [CNT_W-1:0] frame_cnt;
  logic [2:0] step, last_step;
  logic apu_phase, step_done;

  assign reg_sel = apu_reg_pkg::apu_reg_e'(addr);
  assign ch_sel  = addr[2]; // 0x04..0x07 belong to channel 2

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      duty_q <= '0;
      halt_q <= '0;
      const_q <= '0;
      vol_q <= '0;
      sweep_q <= '0;
      period_q <= '0;
      len_idx_q <= '0;
      env_load_q <= '0;
      sweep_load_q <= '0;
      length_load_q <= '0;
      enable <= '0;
    end else begin
      env_load_q <= '0;
      sweep_load_q <= '0;
      length_load_q <= '0;
      if (wr_en) begin
        case (reg_sel)
          apu_reg_pkg::REG_P1_CTRL, apu_reg_pkg::REG_P2_CTRL: begin
            duty_q[ch_sel] <= wdata[7:6];
            halt_q[ch_sel] <= wdata[5];
            const_q[ch_sel] <= wdata[4];
            vol_q[ch_sel] <= wdata[3:0];
            env_load_q[ch_sel] <= 1'b1;
          end
          apu_reg_pkg::REG_P1_SWEEP, apu_reg_pkg::REG_P2_SWEEP: begin
            sweep_q[ch_sel] <= apu_chan_pkg::sweep_t'(wdata);
            sweep_load_q[ch_sel] <= 1'b1;
          end
          apu_reg_pkg::REG_P1_TLO, apu_reg_pkg::REG_P2_TLO: begin
            period_q[ch_sel][7:0] <= wdata;
          end
          apu_reg_pkg::REG_P1_THI, apu_reg_pkg::REG_P2_THI: begin
            period_q[ch_sel][10:8] <= wdata[2:0];
            len_idx_q[ch_sel] <= wdata[7:3];
            length_load_q[ch_sel] <= 1'b1;
            env_load_q[ch_sel] <= 1'b1; // Restarts envelope too
          end
          apu_reg_pkg::REG_STATUS: enable <= wdata[1:0];
          default: ;
        endcase
      end
    end
  end

  assign ch1.duty = duty_q[0];
  assign ch1.length_halt = halt_q[0];
  assign ch1.const_vol = const_q[0];
  assign ch1.vol = vol_q[0];
  assign ch1.sweep_sigs = sweep_q[0];
  assign ch1.timer_period = period_q[0];
  assign ch1.length_load_data = len_idx_q[0];
  assign ch1.env_load = env_load_q[0];
  assign ch1.sweep_load = sweep_load_q[0];
  assign ch1.length_load = length_load_q[0];

  assign ch2.duty = duty_q[1];
  assign ch2.length_halt = halt_q[1];
  assign ch2.const_vol = const_q[1];
  assign ch2.vol = vol_q[1];
  assign ch2.sweep_sigs = sweep_q[1];
  assign ch2.timer_period = period_q[1];
  assign ch2.length_load_data = len_idx_q[1];
  assign ch2.env_load = env_load_q[1];
  assign ch2.sweep_load = sweep_load_q[1];
  assign ch2.length_load = length_load_q[1];

  // Frame sequencer
  assign apu_clk_en = cpu_clk_en && apu_phase;
  assign step_done = apu_clk_en && (frame_cnt == CNT_W'(QUARTER_STEP - 1));
  assign last_step = (frame_mode == apu_reg_pkg::FIVE_STEP) ? 3'd4 : 3'd3;

  always_comb begin
    quarter_clk_en = step_done &&
                     !(frame_mode == apu_reg_pkg::FIVE_STEP && step == 3'd3); // Silent step 4
    half_clk_en = step_done && (step == 3'd1 || step == last_step);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      apu_phase <= 1'b0;
      frame_mode <= apu_reg_pkg::FOUR_STEP;
      frame_cnt <= '0;
      step <= '0;
    end else begin
      if (cpu_clk_en) apu_phase <= ~apu_phase;
      if (wr_en && reg_sel == apu_reg_pkg::REG_FRAME) begin
        frame_mode <= apu_reg_pkg::frame_mode_e'(wdata[7]);
        frame_cnt <= '0;
        step <= '0;
      end else if (step_done) begin
        frame_cnt <= '0;
        step <= (step == last_step) ? 3'd0 : step + 3'd1;
      end else if (apu_clk_en) begin
        frame_cnt <= frame_cnt + 1'b1;
      end
    end
  end

endmodule : apu_ctrl_frontend

//--- apu_pulse_properties.sv
`timescale 1ns/1ps

module apu_pulse_properties (
  input logic clk, rst_n,
  input logic quarter_clk_en, half_clk_en,
  input logic [5:0] load_strobes, // Env, sweep, length for each channel
  input logic [apu_chan_pkg::AUDIO_W-1:0] audio,
  input logic [1:0] status
);

  audio_range: assert property (@(posedge clk) disable iff (!rst_n) audio <= 5'd30)
    else $error("audio level %0d above the two-channel maximum", audio);

  status_in_reset: assert property (@(posedge clk) !rst_n |-> status == 2'b00)
    else $error("status bits not clear during reset");

  half_with_quarter: assert property (@(posedge clk) disable iff (!rst_n)
    half_clk_en |-> quarter_clk_en)
    else $error("half_clk_en without quarter_clk_en");

  single_cycle_load: assert property (@(posedge clk) disable iff (!rst_n)
    (load_strobes & $past(load_strobes)) == '0)
    else $error("load strobe high for more than one cycle");

endmodule : apu_pulse_properties

bind apu_pulse_top apu_pulse_properties props (
  .clk, .rst_n, .quarter_clk_en, .half_clk_en, .audio, .status,
  .load_strobes({ch1_ctrl.env_load, ch1_ctrl.sweep_load, ch1_ctrl.length_load,
                 ch2_ctrl.env_load, ch2_ctrl.sweep_load, ch2_ctrl.length_load}));

//--- apu_pulse_top.sv
`timescale 1ns/1ps

module apu_pulse_top #(parameter int QUARTER_STEP = 3728) (
  input  logic clk, rst_n,
  input  logic cpu_clk_en,
  input  logic wr_en,
  input  logic [apu_reg_pkg::ADDR_W-1:0] addr,
  input  logic [apu_reg_pkg::DATA_W-1:0] wdata,
  output logic [apu_chan_pkg::AUDIO_W-1:0] audio,
  output logic [1:0] status
);

  logic apu_clk_en, quarter_clk_en, half_clk_en;
  logic [1:0] enable;
  logic ch1_active, ch2_active;
  logic [apu_chan_pkg::VOL_W-1:0] ch1_out, ch2_out;

  pulse_ctrl_if ch1_ctrl ();
  pulse_ctrl_if ch2_ctrl ();

  apu_ctrl_frontend #(.QUARTER_STEP(QUARTER_STEP)) frontend (
    .clk, .rst_n, .cpu_clk_en, .wr_en, .addr, .wdata,
    .apu_clk_en, .quarter_clk_en, .half_clk_en, .enable,
    .ch1(ch1_ctrl.frontend), .ch2(ch2_ctrl.frontend));

  pulse_channel #(.PULSE_CHANNEL(1)) pulse1 (
    .clk, .rst_n, .cpu_clk_en, .apu_clk_en, .quarter_clk_en, .half_clk_en,
    .enable(enable[0]), .ctrl(ch1_ctrl.channel),
    .length_non_zero(ch1_active), .out(ch1_out));

  pulse_channel #(.PULSE_CHANNEL(2)) pulse2 (
    .clk, .rst_n, .cpu_clk_en, .apu_clk_en, .quarter_clk_en, .half_clk_en,
    .enable(enable[1]), .ctrl(ch2_ctrl.channel),
    .length_non_zero(ch2_active), .out(ch2_out));

  pulse_mixer mixer (
    .clk, .rst_n, .ch1_out, .ch2_out, .ch1_active, .ch2_active,
    .audio, .status);

endmodule : apu_pulse_top

//--- apu_reg_pkg.sv
package apu_reg_pkg;

  localparam int ADDR_W    = 5;
  localparam int DATA_W    = 8;
  localparam int DUTY_W    = 2;
  localparam int LEN_IDX_W = 5;

  // CPU-visible register map, offset from 0x4000
  typedef enum logic [ADDR_W-1:0] {
    REG_P1_CTRL  = 5'h00, // Duty, halt, const vol, volume
    REG_P1_SWEEP = 5'h01,
    REG_P1_TLO   = 5'h02,
    REG_P1_THI   = 5'h03, // Timer high bits and length index
    REG_P2_CTRL  = 5'h04,
    REG_P2_SWEEP = 5'h05,
    REG_P2_TLO   = 5'h06,
    REG_P2_THI   = 5'h07,
    REG_STATUS   = 5'h15,
    REG_FRAME    = 5'h17
  } apu_reg_e;

  typedef enum logic {
    FOUR_STEP = 1'b0,
    FIVE_STEP = 1'b1
  } frame_mode_e;

endpackage : apu_reg_pkg

//--- length_counter.sv
`timescale 1ns/1ps

module length_counter (
  input  logic clk, rst_n,
  input  logic cpu_clk_en, half_clk_en,
  input  logic halt, enable, load,
  input  logic [apu_reg_pkg::LEN_IDX_W-1:0] load_data,
  output logic non_zero
);

  logic [7:0] count;

  assign non_zero = (count != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (!enable) begin
      count <= '0; // Held clear while disabled
    end else if (load) begin
      count <= apu_chan_pkg::LENGTH_TABLE[load_data];
    end else if (cpu_clk_en && half_clk_en && non_zero && !halt) begin
      count <= count - 8'd1;
    end
  end

endmodule : length_counter

//--- pulse_channel.sv
`timescale 1ns/1ps

module pulse_channel #(parameter int PULSE_CHANNEL = 1) (
  input  logic clk, rst_n,
  input  logic cpu_clk_en, apu_clk_en,
  input  logic quarter_clk_en, half_clk_en,
  input  logic enable,
  pulse_ctrl_if.channel ctrl,
  output logic length_non_zero,
  output logic [apu_chan_pkg::VOL_W-1:0] out
);

  logic mute, sweep_change;
  logic timer_pulse, seq_out;
  logic [apu_chan_pkg::TIMER_W-1:0] cur_period, period_seen, sweep_period, timer_cnt;
  logic [2:0] seq_i;
  logic [apu_chan_pkg::VOL_W-1:0] env_vol, gate1_out, gate2_out;

  assign timer_pulse = cpu_clk_en && apu_clk_en && (timer_cnt == '0);
  assign seq_out = apu_chan_pkg::DUTY_SEQ[ctrl.duty][seq_i];

  always_comb begin
    gate1_out = mute ? '0 : env_vol;
    gate2_out = seq_out ? gate1_out : '0;
    out = length_non_zero ? gate2_out : '0;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cur_period <= '0;
      period_seen <= '0;
      timer_cnt <= '0;
      seq_i <= '0;
    end else begin
      // A register write wins over a sweep update
      if (ctrl.timer_period != period_seen) begin
        period_seen <= ctrl.timer_period;
        cur_period <= ctrl.timer_period;
      end else if (sweep_change) begin
        cur_period <= sweep_period;
      end
      if (cpu_clk_en && apu_clk_en)
        timer_cnt <= (timer_cnt == '0) ? cur_period : timer_cnt - 1'b1;
      if (ctrl.length_load)
        seq_i <= '0;
      else if (timer_pulse)
        seq_i <= seq_i + 3'd1;
    end
  end

  pulse_sweep #(.CARRY(PULSE_CHANNEL)) sweep_unit (
    .clk, .rst_n, .cpu_clk_en, .half_clk_en,
    .load(ctrl.sweep_load), .sweep_sigs(ctrl.sweep_sigs),
    .timer_period_in(cur_period), .mute,
    .change_timer_period(sweep_change), .timer_period_out(sweep_period));

  pulse_envelope env_unit (
    .clk, .rst_n, .cpu_clk_en, .quarter_clk_en, .load(ctrl.env_load),
    .loop_flag(ctrl.length_halt), .const_vol(ctrl.const_vol),
    .vol_in(ctrl.vol), .vol_out(env_vol));

  length_counter len_counter (
    .clk, .rst_n, .cpu_clk_en, .half_clk_en, .halt(ctrl.length_halt), .enable,
    .load(ctrl.length_load), .load_data(ctrl.length_load_data),
    .non_zero(length_non_zero));

endmodule : pulse_channel

//--- pulse_ctrl_if.sv
`timescale 1ns/1ps

interface pulse_ctrl_if;

  logic [apu_reg_pkg::DUTY_W-1:0]    duty;
  logic                              length_halt; // Doubles as envelope loop
  logic                              const_vol;
  logic [apu_chan_pkg::VOL_W-1:0]    vol;
  apu_chan_pkg::sweep_t              sweep_sigs;
  logic [apu_chan_pkg::TIMER_W-1:0]  timer_period;
  logic [apu_reg_pkg::LEN_IDX_W-1:0] length_load_data;
  logic                              env_load;
  logic                              sweep_load;
  logic                              length_load;

  modport frontend (
    output duty, length_halt, const_vol, vol, sweep_sigs, timer_period,
    output length_load_data, env_load, sweep_load, length_load
  );

  modport channel (
    input duty, length_halt, const_vol, vol, sweep_sigs, timer_period,
    input length_load_data, env_load, sweep_load, length_load
  );

endinterface : pulse_ctrl_if

//--- pulse_envelope.sv
`timescale 1ns/1ps

module pulse_envelope (
  input  logic clk, rst_n,
  input  logic cpu_clk_en, quarter_clk_en,
  input  logic load, loop_flag, const_vol,
  input  logic [apu_chan_pkg::VOL_W-1:0] vol_in, // Also the divider period
  output logic [apu_chan_pkg::VOL_W-1:0] vol_out
);

  logic start;
  logic [apu_chan_pkg::VOL_W-1:0] div_cnt, decay;

  assign vol_out = const_vol ? vol_in : decay;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start <= 1'b0;
      div_cnt <= '0;
      decay <= '0;
    end else begin
      if (cpu_clk_en && quarter_clk_en) begin
        if (start) begin
          start <= 1'b0;
          decay <= '1;
          div_cnt <= vol_in;
        end else if (div_cnt == '0) begin
          div_cnt <= vol_in;
          if (decay != '0)
            decay <= decay - 1'b1;
          else if (loop_flag)
            decay <= '1; // Wrap back to 15
        end else begin
          div_cnt <= div_cnt - 1'b1;
        end
      end
      if (load) start <= 1'b1;
    end
  end

endmodule : pulse_envelope

//--- pulse_mixer.sv
`timescale 1ns/1ps

module pulse_mixer (
  input  logic clk, rst_n,
  input  logic [apu_chan_pkg::VOL_W-1:0] ch1_out, ch2_out,
  input  logic ch1_active, ch2_active,
  output logic [apu_chan_pkg::AUDIO_W-1:0] audio,
  output logic [1:0] status
);

  localparam int AW = apu_chan_pkg::AUDIO_W;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      audio <= '0;
      status <= '0;
    end else begin
      audio <= AW'(ch1_out) + AW'(ch2_out); // Linear sum, max 30
      status <= {ch2_active, ch1_active};
    end
  end

endmodule : pulse_mixer

//--- pulse_sweep.sv
`timescale 1ns/1ps

module pulse_sweep #(parameter int CARRY = 1) (
  input  logic clk, rst_n,
  input  logic cpu_clk_en, half_clk_en,
  input  logic load,
  input  apu_chan_pkg::sweep_t sweep_sigs,
  input  logic [apu_chan_pkg::TIMER_W-1:0] timer_period_in,
  output logic mute,
  output logic change_timer_period,
  output logic [apu_chan_pkg::TIMER_W-1:0] timer_period_out
);

  localparam int TW = apu_chan_pkg::TIMER_W;
  localparam logic [TW:0] BORROW = (CARRY == 1) ? 1 : 0; // Ones' complement on channel 1

  logic [TW:0] change_amt, target;
  logic [2:0] div_cnt;
  logic reload;

  always_comb begin
    change_amt = {1'b0, timer_period_in} >> sweep_sigs.shift_count;
    if (sweep_sigs.negate)
      target = {1'b0, timer_period_in} - change_amt - BORROW;
    else
      target = {1'b0, timer_period_in} + change_amt;
  end

  assign mute = (timer_period_in < TW'(8)) || target[TW]; // Above 0x7FF
  assign timer_period_out = target[TW-1:0];
  assign change_timer_period = cpu_clk_en && half_clk_en && (div_cnt == '0) &&
                               sweep_sigs.enable && !mute &&
                               (sweep_sigs.shift_count != '0);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      div_cnt <= '0;
      reload <= 1'b0;
    end else begin
      if (cpu_clk_en && half_clk_en) begin
        if (div_cnt == '0 || reload) begin
          div_cnt <= sweep_sigs.period;
          reload <= 1'b0;
        end else begin
          div_cnt <= div_cnt - 3'd1;
        end
      end
      if (load) reload <= 1'b1;
    end
  end

endmodule : pulse_sweep

//--- tb.f
apu_reg_pkg.sv
apu_chan_pkg.sv
pulse_ctrl_if.sv
apu_ctrl_frontend.sv
length_counter.sv
pulse_envelope.sv
pulse_sweep.sv
pulse_channel.sv
pulse_mixer.sv
apu_pulse_top.sv
apu_pulse_properties.sv
tb_apu_pulse.sv

//--- tb_apu_pulse.sv
`timescale 1ns/1ps

module tb_clock #(parameter int PERIOD_NS = 100) (output logic clk);
  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end
endmodule : tb_clock

module tb_apu_pulse;

  localparam int QUARTER_STEP = 40;
  localparam int CPQ = 2 * QUARTER_STEP; // Cycles per quarter strobe
  localparam int FRAME = 4 * CPQ;        // Four-step frame in cycles
  localparam int BUDGET_FRAMES = 3 + 5 + 8 + 10 + 20 + 3; // In test order
  localparam int WATCHDOG_NS = (BUDGET_FRAMES + 10) * FRAME * 100;

  logic clk, rst_n, cpu_clk_en, wr_en;
  logic [apu_reg_pkg::ADDR_W-1:0] addr;
  logic [apu_reg_pkg::DATA_W-1:0] wdata;
  logic [apu_chan_pkg::AUDIO_W-1:0] audio;
  logic [1:0] status;

  tb_clock #(.PERIOD_NS(100)) clock_gen (.clk);

  apu_pulse_top #(.QUARTER_STEP(QUARTER_STEP)) dut0 (
    .clk, .rst_n, .cpu_clk_en, .wr_en, .addr, .wdata, .audio, .status);

  task automatic stop_with_failure(string reason);
    $display("%s", reason);
    $display("Some tests failed");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_audio(string test, logic [apu_chan_pkg::AUDIO_W-1:0] exp, act);
    if (act !== exp)
      stop_with_failure($sformatf("Error: %s: expected audio %0d, got %0d", test, exp, act));
  endtask

  task automatic check_status(string test, logic [1:0] exp, act);
    if (act !== exp)
      stop_with_failure($sformatf("Error: %s: expected status %b, got %b", test, exp, act));
  endtask

  task automatic compare_hits(string test, int exp, act);
    if (act != exp)
      stop_with_failure($sformatf("Error: %s: expected count %0d, got %0d", test, exp, act));
  endtask

  // High steps out of 8 for 12.5, 25, 50 and 75 percent
  function automatic int duty_high_steps(int duty);
    case (duty)
      0: return 1;
      1: return 2;
      2: return 4;
      default: return 6;
    endcase
  endfunction

  task automatic write_reg(apu_reg_pkg::apu_reg_e reg_addr,
                           logic [apu_reg_pkg::DATA_W-1:0] data);
    @(posedge clk);
    wr_en <= 1'b1;
    addr <= reg_addr;
    wdata <= data;
    @(posedge clk);
    wr_en <= 1'b0;
  endtask

  task automatic program_channel(int ch, int duty, logic halt, logic const_v, int vol,
                                 int period, int len_idx);
    write_reg(ch == 1 ? apu_reg_pkg::REG_P1_CTRL : apu_reg_pkg::REG_P2_CTRL,
              {2'(duty), halt, const_v, 4'(vol)});
    write_reg(ch == 1 ? apu_reg_pkg::REG_P1_TLO : apu_reg_pkg::REG_P2_TLO, 8'(period));
    write_reg(ch == 1 ? apu_reg_pkg::REG_P1_THI : apu_reg_pkg::REG_P2_THI,
              {5'(len_idx), 3'(period >> 8)});
  endtask

  task automatic reset_idle();
    repeat (2 * FRAME) begin
      @(negedge clk);
      check_audio("reset", '0, audio);
      check_status("reset", 2'b00, status);
    end
  endtask

  task automatic duty_cycle();
    int d, v, p, hits;
    d = $urandom_range(3, 0);
    v = $urandom_range(15, 1);
    p = $urandom_range(40, 8);
    hits = 0;
    write_reg(apu_reg_pkg::REG_STATUS, 8'h01);
    program_channel(1, d, 1'b1, 1'b1, v, p, 1); // Index 1 is the longest length
    repeat (16 * (p + 1) + 8) @(negedge clk);
    repeat (16 * (p + 1)) begin
      @(negedge clk);
      if (audio == v)
        hits++;
      else
        check_audio("duty", '0, audio);
    end
    compare_hits("duty", duty_high_steps(d) * 2 * (p + 1), hits);
  endtask

  task automatic channel_sum();
    int v1, v2, p1, p2;
    logic seen_both;
    v1 = $urandom_range(15, 1);
    v2 = $urandom_range(15, 1);
    p1 = $urandom_range(40, 8);
    p2 = $urandom_range(40, 8);
    seen_both = 1'b0;
    write_reg(apu_reg_pkg::REG_STATUS, 8'h03);
    program_channel(1, 3, 1'b1, 1'b1, v1, p1, 1);
    program_channel(2, 3, 1'b1, 1'b1, v2, p2, 1);
    repeat (16 * 41) @(negedge clk);
    repeat (32 * 41) begin
      @(negedge clk);
      if (audio == v1 + v2)
        seen_both = 1'b1;
      else if (audio != 0 && audio != v1 && audio != v2)
        stop_with_failure($sformatf("Error: sum: expected one of 0, %0d, %0d, %0d, got %0d",
                                    v1, v2, v1 + v2, audio));
    end
    if (!seen_both)
      stop_with_failure("Sum test never saw both channels high at the same time");
  endtask

  task automatic length_expiry();
    int m;
    write_reg(apu_reg_pkg::REG_STATUS, 8'h01);
    write_reg(apu_reg_pkg::REG_FRAME, 8'h00); // Four-step, sequencer restarts here
    program_channel(1, 2, 1'b0, 1'b1, 8, 20, 0); // Index 0 loads 10
    m = 6; // Edges since the frame restart
    forever begin
      @(negedge clk);
      if (!status[0] || m >= 8 * FRAME) break;
      m++;
    end
    if (status[0])
      stop_with_failure("Length counter of channel 1 never expired");
    compare_hits("length half strobes", 10, m / (2 * CPQ)); // Two per frame
    write_reg(apu_reg_pkg::REG_P1_THI, {5'd1, 3'd0});
    repeat (3) @(negedge clk);
    check_status("length reload", 2'b01, status);
    write_reg(apu_reg_pkg::REG_STATUS, 8'h00);
    repeat (2) @(posedge clk);
    @(negedge clk);
    check_status("length disable", 2'b00, status);
  endtask

  task automatic envelope_decay();
    int e, per, m, rel;
    logic [apu_chan_pkg::AUDIO_W-1:0] peak [16];
    e = $urandom_range(3, 0);
    per = (e + 1) * CPQ;
    foreach (peak[k]) peak[k] = '0;
    write_reg(apu_reg_pkg::REG_STATUS, 8'h01);
    write_reg(apu_reg_pkg::REG_FRAME, 8'h00);
    program_channel(1, 3, 1'b0, 1'b0, e, 8, 1);
    for (m = 6; m < CPQ + 16 * per; m++) begin
      @(negedge clk);
      rel = m - CPQ; // First quarter strobe sets the level to 15
      // Skip samples close to a level change
      if (rel >= 0 && rel % per >= 4 && rel % per < per - 4 && audio > peak[rel / per])
        peak[rel / per] = audio;
    end
    foreach (peak[k])
      check_audio($sformatf("envelope period %0d", k), 5'(15 - k), peak[k]);
    repeat (2 * per) begin
      @(negedge clk);
      check_audio("envelope end", '0, audio);
      check_status("envelope end", 2'b01, status);
    end
  endtask

  task automatic sweep_mute();
    write_reg(apu_reg_pkg::REG_STATUS, 8'h01);
    program_channel(1, 2, 1'b1, 1'b0, 9, 5, 1); // Period below 8
    repeat (4 * CPQ) begin
      @(negedge clk);
      check_audio("sweep mute", '0, audio);
    end
    check_status("sweep mute", 2'b01, status);
  endtask

  initial begin
    #(WATCHDOG_NS);
    stop_with_failure("Watchdog expired before the tests finished");
  end

  initial begin
    void'($urandom(99959));
    rst_n = 1'b0;
    cpu_clk_en = 1'b1;
    wr_en = 1'b0;
    addr = '0;
    wdata = '0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    reset_idle();
    duty_cycle();
    channel_sum();
    length_expiry();
    envelope_decay();
    sweep_mute();
    $display("All tests passed");
    $finish;
  end

endmodule : tb_apu_pulse
